// File: src/bus_pkg.sv
/*
 * system bus definitions shared by the fabric and its testbench
 * widths, master request struct, device index and the i/o page map
 * addresses are 17 bit, bit 16 is the console mode bit
 */
`default_nettype none

package bus_pkg;

   // **************************************************
   // bus geometry
   // **************************************************
   localparam int ADR_W       = 17;           // word address incl. console bit
   localparam int DAT_W       = 16;
   localparam int CONSOLE_BIT = ADR_W - 1;    // flips the dram window
   localparam int NUM_DMA     = 2;            // rk and my disk controllers

   // one master's request, classic wishbone
   typedef struct packed {
      logic [ADR_W-1:0] adr;
      logic [DAT_W-1:0] dat;                  // write data
      logic             cyc;
      logic             we;
      logic [1:0]       sel;                  // byte lanes
      logic             stb;
   } wb_req_t;

   // **************************************************
   // devices on the bus
   // **************************************************
   typedef enum logic [3:0] {
      DEV_ROM, DEV_DRAM, DEV_UART1, DEV_UART2, DEV_LPT,
      DEV_RK, DEV_DW, DEV_RX, DEV_MY, DEV_KGD
   } dev_id_e;

   localparam int NUM_DEV = 10;

   typedef logic [NUM_DEV-1:0] dev_sel_t;     // one bit per dev_id_e

   // i/o page, base address and block size as 2**n bytes
   localparam logic [ADR_W-1:0] UART1_BASE = 17'o177560;  // console tty
   localparam int               UART1_SZ   = 3;
   localparam logic [ADR_W-1:0] UART2_BASE = 17'o176500;
   localparam int               UART2_SZ   = 3;
   localparam logic [ADR_W-1:0] LPT_BASE   = 17'o177514;  // printer
   localparam int               LPT_SZ     = 2;
   localparam logic [ADR_W-1:0] RK_BASE    = 17'o177400;
   localparam int               RK_SZ      = 4;
   localparam logic [ADR_W-1:0] DW_BASE    = 17'o174000;  // hard disk
   localparam int               DW_SZ      = 5;
   localparam logic [ADR_W-1:0] RX_BASE    = 17'o177170;
   localparam int               RX_SZ      = 2;
   localparam logic [ADR_W-1:0] MY_BASE    = 17'o172140;  // floppy
   localparam int               MY_SZ      = 2;
   localparam logic [ADR_W-1:0] KGD_BASE   = 17'o176640;  // graphics
   localparam int               KGD_SZ     = 3;

   localparam logic [3:0] ROM_TAG = 4'b1110;  // adr[16:13] of monitor rom

endpackage

`default_nettype wire

// File: src/sd_pkg.sv
/*
 * sd card sharing definitions
 * spi lines driven by one disk controller, and the controller count
 * controller order is rk, dw, rx, my
 */
`default_nettype none

package sd_pkg;

   // **************************************************
   // card side lines owned by a controller
   // **************************************************
   typedef struct packed {
      logic mosi;    // spi data to card
      logic cs;      // chip select, low active on the card
   } sd_lines_t;

   // controllers sharing the card
   localparam int NUM_SD = 4;

   // port index of each controller
   localparam int SD_RK = 0;
   localparam int SD_DW = 1;
   localparam int SD_RX = 2;
   localparam int SD_MY = 3;

endpackage

`default_nettype wire

// File: src/bus_master_arbiter.sv
/*
 * bus master arbiter, cpu plus dma masters
 * dma grants switch only between bus cycles, lowest dma index first
 * the granted master is routed to the bus and alone sees the ack
 */
`timescale 1ns/1ps
`default_nettype none

module bus_master_arbiter #(
   parameter int NUM_DMA_P = bus_pkg::NUM_DMA
) (
   input  logic                             wb_clk,
   input  logic                             rst_i,
   input  bus_pkg::wb_req_t                 cpu_req_i,   // cpu, default owner
   input  bus_pkg::wb_req_t [NUM_DMA_P-1:0] dma_req_i,   // disk dma masters
   output bus_pkg::wb_req_t                 bus_req_o,   // forwarded request
   input  logic                             bus_ack_i,
   output logic                             cpu_gnt_o,
   output logic                             cpu_ack_o,
   output logic [NUM_DMA_P-1:0]             dma_gnt_o,
   output logic [NUM_DMA_P-1:0]             dma_ack_o
);
   import bus_pkg::*;

   logic [NUM_DMA_P-1:0] dma_gnt_q;     // one grant flop per dma master
   logic [NUM_DMA_P-1:0] gnt_nxt;       // priority pick of requesters
   logic                 pick_found;
   wb_req_t              dma_sel;       // request of the granted dma master

   // **************************************************
   // grant selection
   // **************************************************
   always_comb begin
      gnt_nxt    = '0;
      pick_found = 1'b0;
      for (int i = 0; i < NUM_DMA_P; i++) begin
         if (dma_req_i[i].cyc && !pick_found) begin  // dma request is its cyc
            gnt_nxt[i] = 1'b1;
            pick_found = 1'b1;
         end
      end
   end

   // switch only while no cycle is open on the bus
   always_ff @(posedge wb_clk) begin
      if (rst_i) begin
         dma_gnt_q <= '0;
      end else if (!bus_req_o.cyc) begin
         dma_gnt_q <= gnt_nxt;            // all zero hands the bus to cpu
      end
   end

   assign dma_gnt_o = dma_gnt_q;
   assign cpu_gnt_o = ~|dma_gnt_q;

   // **************************************************
   // request mux
   // **************************************************
   always_comb begin
      dma_sel = '0;
      for (int i = 0; i < NUM_DMA_P; i++) begin
         if (dma_gnt_q[i]) begin
            dma_sel = dma_req_i[i];
         end
      end
   end

   always_comb begin
      if (cpu_gnt_o) begin
         bus_req_o = cpu_req_i;
      end else begin
         bus_req_o     = dma_sel;        // cyc comes from the dma request
         bus_req_o.sel = 2'b11;          // dma moves whole words
      end
   end

   // ack back to the owner only
   assign cpu_ack_o = cpu_gnt_o & bus_ack_i;
   assign dma_ack_o = dma_gnt_q & {NUM_DMA_P{bus_ack_i}};

   // **************************************************
   // checks
   // **************************************************
   a_dma_gnt_onehot: assert property (
      @(posedge wb_clk) disable iff (rst_i)
      $onehot0(dma_gnt_q)
   );

endmodule

`default_nettype wire

// File: src/io_page_decoder.sv
/*
 * address decoder for the i/o page, rom and dram windows
 * one strobe per device, gated by cyc and stb
 * device acks are ored, read data muxed from the strobed device
 * all paths combinational, wb_clk is only used by the check below
 */
`timescale 1ns/1ps
`default_nettype none

module io_page_decoder (
   input  logic                                           wb_clk,
   input  bus_pkg::wb_req_t                               bus_req_i,
   output bus_pkg::dev_sel_t                              dev_stb_o,
   input  bus_pkg::dev_sel_t                              dev_ack_i,
   input  logic [bus_pkg::NUM_DEV-1:0][bus_pkg::DAT_W-1:0] dev_dat_i,
   output logic                                           bus_ack_o,
   output logic [bus_pkg::DAT_W-1:0]                      bus_rdat_o
);
   import bus_pkg::*;

   logic [ADR_W-1:0] adr;
   logic             bus_act;       // cyc and stb both up
   logic             con_mode;      // console mode address bit
   logic             low_win;       // adr[15:13] below the top 8k
   dev_sel_t         dev_hit;       // raw address match, ungated
   dev_sel_t         dev_stb;
   logic [DAT_W-1:0] rdat;

   // address inside a 2**sz byte block at base
   function automatic logic in_block(
      input logic [ADR_W-1:0] a,
      input logic [ADR_W-1:0] base,
      input int               sz
   );
      logic [ADR_W-1:0] a_blk;
      logic [ADR_W-1:0] b_blk;
      a_blk = a >> sz;
      b_blk = base >> sz;
      return a_blk == b_blk;
   endfunction

   assign adr      = bus_req_i.adr;
   assign bus_act  = bus_req_i.cyc & bus_req_i.stb;
   assign con_mode = adr[CONSOLE_BIT];
   assign low_win  = adr[CONSOLE_BIT-1 -: 3] != 3'b111;

   // **************************************************
   // address decode
   // **************************************************
   always_comb begin
      dev_hit = '0;

      // monitor rom, console mode shadow at 140000
      dev_hit[DEV_ROM]  = adr[CONSOLE_BIT -: 4] == ROM_TAG;
      // user mode: 000000-157776, console mode: 160000-177776
      dev_hit[DEV_DRAM] = low_win ^ con_mode;

      // i/o page registers, only reachable with console bit clear
      dev_hit[DEV_UART1] = in_block(adr, UART1_BASE, UART1_SZ);
      dev_hit[DEV_UART2] = in_block(adr, UART2_BASE, UART2_SZ);
      dev_hit[DEV_LPT]   = in_block(adr, LPT_BASE, LPT_SZ);
      dev_hit[DEV_RK]    = in_block(adr, RK_BASE, RK_SZ);
      dev_hit[DEV_DW]    = in_block(adr, DW_BASE, DW_SZ);
      dev_hit[DEV_RX]    = in_block(adr, RX_BASE, RX_SZ);
      dev_hit[DEV_MY]    = in_block(adr, MY_BASE, MY_SZ);
      dev_hit[DEV_KGD]   = in_block(adr, KGD_BASE, KGD_SZ);
   end

   // no strobe outside a cycle
   assign dev_stb   = bus_act ? dev_hit : '0;
   assign dev_stb_o = dev_stb;

   // **************************************************
   // response path
   // **************************************************
   assign bus_ack_o = |dev_ack_i;   // idle devices keep ack low

   always_comb begin
      rdat = '0;
      for (int i = 0; i < NUM_DEV; i++) begin
         if (dev_stb[i]) begin
            rdat = rdat | dev_dat_i[i];   // unselected devices masked off
         end
      end
   end

   assign bus_rdat_o = rdat;

   // **************************************************
   // checks
   // **************************************************
   // map has no overlaps, including rom against dram
   a_stb_onehot: assert property (
      @(posedge wb_clk)
      $onehot0(dev_stb_o)
   );

endmodule

`default_nettype wire

// File: src/sd_card_arbiter.sv
/*
 * sd card access arbiter, one spi card for several disk controllers
 * idle card goes to the lowest numbered requester
 * the owner keeps the card until it drops its request
 */
`timescale 1ns/1ps
`default_nettype none

module sd_card_arbiter #(
   parameter int NUM_SD_P        = sd_pkg::NUM_SD,
   parameter int DEFAULT_SD_PORT = 0              // drives the idle card
) (
   input  logic                             wb_clk,
   input  logic                             rst_i,
   input  logic [NUM_SD_P-1:0]              sd_req_i,
   input  sd_pkg::sd_lines_t [NUM_SD_P-1:0] sd_lines_i,
   output logic [NUM_SD_P-1:0]              sd_ack_o,
   output sd_pkg::sd_lines_t                sd_lines_o
);
   import sd_pkg::*;

   logic [NUM_SD_P-1:0] sd_ack_q;     // current owner, one-hot
   logic [NUM_SD_P-1:0] pick;         // first requester
   logic                pick_found;
   sd_lines_t           owner_lines;

   // **************************************************
   // ownership
   // **************************************************
   always_comb begin
      pick       = '0;
      pick_found = 1'b0;
      for (int n = 0; n < NUM_SD_P; n++) begin
         if (sd_req_i[n] && !pick_found) begin
            pick[n]    = 1'b1;
            pick_found = 1'b1;
         end
      end
   end

   always_ff @(posedge wb_clk) begin
      if (rst_i) begin
         sd_ack_q <= '0;
      end else if (sd_ack_q == '0) begin
         sd_ack_q <= pick;                 // idle, hand out the card
      end else begin
         sd_ack_q <= sd_ack_q & sd_req_i;  // busy, release on drop
      end
   end

   assign sd_ack_o = sd_ack_q;

   // **************************************************
   // spi line mux
   // **************************************************
   always_comb begin
      owner_lines = sd_lines_i[DEFAULT_SD_PORT];
      for (int n = 0; n < NUM_SD_P; n++) begin
         if (sd_ack_q[n]) begin
            owner_lines = sd_lines_i[n];
         end
      end
   end

   assign sd_lines_o = owner_lines;

   // **************************************************
   // checks
   // **************************************************
   a_ack_onehot: assert property (
      @(posedge wb_clk) disable iff (rst_i)
      $onehot0(sd_ack_q)
   );

   for (genvar n = 0; n < NUM_SD_P; n++) begin : g_ack_chk
      a_ack_needs_req: assert property (
         @(posedge wb_clk) disable iff (rst_i)
         $rose(sd_ack_q[n]) |-> $past(sd_req_i[n])
      );
   end

endmodule

`default_nettype wire

// File: src/system_bus_fabric.sv
/*
 * system bus fabric top
 * bus path is master arbiter then i/o page decoder
 * sd card arbiter runs beside it and shares only clock and reset
 */
`timescale 1ns/1ps
`default_nettype none

module system_bus_fabric #(
   parameter int NUM_DMA_P       = bus_pkg::NUM_DMA,
   parameter int NUM_SD_P        = sd_pkg::NUM_SD,
   parameter int DEFAULT_SD_PORT = 0
) (
   input  logic                                           wb_clk,
   input  logic                                           rst_i,
   // masters
   input  bus_pkg::wb_req_t                               cpu_req_i,
   input  bus_pkg::wb_req_t [NUM_DMA_P-1:0]               dma_req_i,
   output logic                                           cpu_gnt_o,
   output logic                                           cpu_ack_o,
   output logic [NUM_DMA_P-1:0]                           dma_gnt_o,
   output logic [NUM_DMA_P-1:0]                           dma_ack_o,
   output logic [bus_pkg::DAT_W-1:0]                      rd_dat_o,  // to all masters
   // devices
   output bus_pkg::wb_req_t                               bus_o,
   output bus_pkg::dev_sel_t                              dev_stb_o,
   input  bus_pkg::dev_sel_t                              dev_ack_i,
   input  logic [bus_pkg::NUM_DEV-1:0][bus_pkg::DAT_W-1:0] dev_dat_i,
   // sd card
   input  logic [NUM_SD_P-1:0]                            sd_req_i,
   input  sd_pkg::sd_lines_t [NUM_SD_P-1:0]               sd_lines_i,
   output logic [NUM_SD_P-1:0]                            sd_ack_o,
   output sd_pkg::sd_lines_t                              sd_lines_o
);
   import bus_pkg::*;

   wb_req_t          bus_req;    // arbiter to decoder
   logic             bus_ack;    // decoder back to arbiter
   logic [DAT_W-1:0] bus_rdat;

   assign bus_o    = bus_req;
   assign rd_dat_o = bus_rdat;

   // **************************************************
   // bus path
   // **************************************************
   bus_master_arbiter #(.NUM_DMA_P(NUM_DMA_P)) bus_master_arbiter_i (
      .wb_clk    (wb_clk),
      .rst_i     (rst_i),
      .cpu_req_i (cpu_req_i),
      .dma_req_i (dma_req_i),
      .bus_req_o (bus_req),
      .bus_ack_i (bus_ack),
      .cpu_gnt_o (cpu_gnt_o),
      .cpu_ack_o (cpu_ack_o),
      .dma_gnt_o (dma_gnt_o),
      .dma_ack_o (dma_ack_o)
   );

   io_page_decoder io_page_decoder_i (
      .wb_clk     (wb_clk),       // check clock only
      .bus_req_i  (bus_req),
      .dev_stb_o  (dev_stb_o),
      .dev_ack_i  (dev_ack_i),
      .dev_dat_i  (dev_dat_i),
      .bus_ack_o  (bus_ack),
      .bus_rdat_o (bus_rdat)
   );

   // **************************************************
   // sd card sharing
   // **************************************************
   sd_card_arbiter #(
      .NUM_SD_P        (NUM_SD_P),
      .DEFAULT_SD_PORT (DEFAULT_SD_PORT)
   ) sd_card_arbiter_i (
      .wb_clk     (wb_clk),
      .rst_i      (rst_i),
      .sd_req_i   (sd_req_i),
      .sd_lines_i (sd_lines_i),
      .sd_ack_o   (sd_ack_o),
      .sd_lines_o (sd_lines_o)
   );

endmodule

`default_nettype wire

// File: verif/tb_fabric_tasks.svh
/*
 * directed tests for the bus fabric testbench, included in its module
 * tests start and end 2 ns after a rising edge, outputs sampled at the falling edge
 */
`ifndef TB_FABRIC_TASKS_SVH
`define TB_FABRIC_TASKS_SVH

   localparam int ACK_LIMIT = 8;       // clocks a device may take
   localparam int NO_DEV    = -1;

   // i/o page map, indexed by device
   localparam logic [ADR_W-1:0] IO_BASE [NUM_DEV] = '{17'o0, 17'o0, UART1_BASE,
      UART2_BASE, LPT_BASE, RK_BASE, DW_BASE, RX_BASE, MY_BASE, KGD_BASE};
   localparam int IO_SZ [NUM_DEV] = '{0, 0, UART1_SZ, UART2_SZ, LPT_SZ, RK_SZ,
      DW_SZ, RX_SZ, MY_SZ, KGD_SZ};

   // rom is 1110 in bits 16..13, dram is (15..13 != 111) xor bit 16
   localparam logic [ADR_W-1:0] WIN_ADR [6] = '{17'o000000, 17'o140000, 17'o160000,
      17'o300000, 17'o340000, 17'o360000};
   localparam int WIN_DEV [6] = '{DEV_DRAM, DEV_DRAM, NO_DEV, NO_DEV, DEV_ROM, DEV_DRAM};

   task automatic expect_eq(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
      if (got !== exp) begin
         $display("mismatch %s: got %h expected %h", name, got, exp);
         err_cnt++;
         test_err++;
      end
   endtask

   task automatic end_test(input string name);
      test_cnt++;
      if (test_err == 0) begin
         $display("test %s: ok", name);
      end else begin
         $display("test %s: %0d errors", name, test_err);
         fail_cnt++;
      end
      test_err = 0;
   endtask

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // x^32+x^22+x^2+x+1
   endfunction

   task automatic rand_bits(input int n, output logic [15:0] v);
      v = '0;
      for (int k = 0; k < n; k++) begin
         lfsr_q = lfsr_next(lfsr_q);
         v      = {v[14:0], lfsr_q[0]};
      end
   endtask

   // device index times 1111 hex, xor low address byte
   function automatic logic [DAT_W-1:0] model_data(input int idx, input logic [ADR_W-1:0] adr);
      logic [DAT_W-1:0] k;
      k = DAT_W'(idx);
      return (k * 16'h1111) ^ {8'h00, adr[7:0]};
   endfunction

   task automatic drive_edge();
      @(posedge wb_clk);
      #DRV_DLY;
   endtask

   task automatic wait_falls(input int n);
      repeat (n) @(negedge wb_clk);
   endtask

   task automatic wait_ack(input string what, output logic got);
      int n;
      n   = 0;
      got = 1'b0;
      while (!got && n < ACK_LIMIT) begin
         @(negedge wb_clk);
         got = cpu_ack | (|dma_ack);
         n++;
      end
      if (!got) begin
         $display("no ack within %0d cycles for %s", ACK_LIMIT, what);
         err_cnt++;
         test_err++;
      end
   endtask

   task automatic cpu_read(input logic [ADR_W-1:0] adr, input int dev);
      dev_sel_t exp_stb;
      logic     got;
      exp_stb = '0;
      if (dev >= 0) exp_stb[dev] = 1'b1;
      cpu_req     = '0;
      cpu_req.adr = adr;
      cpu_req.sel = 2'b11;
      cpu_req.cyc = 1'b1;
      cpu_req.stb = 1'b1;
      wait_falls(1);
      expect_eq("dev_stb_o", 32'(dev_stb), 32'(exp_stb));
      if (dev < 0) begin
         wait_falls(1);
         expect_eq("cpu_ack_o", 32'(cpu_ack), 32'h0);   // nobody answers
      end else begin
         wait_ack("cpu read", got);
         if (got) expect_eq("rd_dat_o", 32'(rd_dat), 32'(model_data(dev, adr)));
      end
      drive_edge();
      cpu_req = '0;
   endtask

   task automatic dma_start(input int m, input logic [ADR_W-1:0] adr, input logic we);
      logic [15:0] d;
      rand_bits(16, d);
      dma_req[m].adr = adr;
      dma_req[m].dat = d;
      dma_req[m].we  = we;
      dma_req[m].sel = 2'b01;          // narrow, fabric widens it
      dma_req[m].cyc = 1'b1;
      dma_req[m].stb = 1'b1;
   endtask

   // called at the falling edge after the grant
   task automatic dma_finish(input int m, input int dev);
      logic got;
      expect_eq("bus_o.sel", 32'(bus_view.sel), 32'h3);
      expect_eq("bus_o.we", 32'(bus_view.we), 32'(dma_req[m].we));
      expect_eq("bus_o.adr", 32'(bus_view.adr), 32'(dma_req[m].adr));
      expect_eq("bus_o.dat", 32'(bus_view.dat), 32'(dma_req[m].dat));
      wait_ack("dma cycle", got);
      if (got) begin
         expect_eq("dma_ack_o", 32'(dma_ack), 32'(1 << m));
         expect_eq("cpu_ack_o", 32'(cpu_ack), 32'h0);
         expect_eq("rd_dat_o", 32'(rd_dat), 32'(model_data(dev, dma_req[m].adr)));
      end
      drive_edge();
      dma_req[m] = '0;
   endtask

   task automatic check_gnt(input logic [NUM_DMA-1:0] exp);
      expect_eq("dma_gnt_o", 32'(dma_gnt), 32'(exp));
      expect_eq("cpu_gnt_o", 32'(cpu_gnt), 32'(exp == '0));
   endtask

   // **************************************************
   // directed tests
   // **************************************************
   task automatic test_reset_state();
      wait_falls(1);
      check_gnt(2'b00);
      expect_eq("sd_ack_o", 32'(sd_ack), 32'h0);
      expect_eq("sd_lines_o", 32'(sd_lines_out), 32'(sd_lines[SD_DEF_PORT]));
      drive_edge();
      end_test("reset state");
   endtask

   task automatic test_decode();
      logic [15:0]      ofs;
      logic [ADR_W-1:0] adr;
      for (int i = int'(DEV_UART1); i < NUM_DEV; i++) begin
         rand_bits(IO_SZ[i], ofs);       // anywhere in the block
         adr = IO_BASE[i] | ADR_W'(ofs);
         cpu_read(adr, i);
      end
      for (int w = 0; w < 6; w++) begin
         rand_bits(12, ofs);
         adr = WIN_ADR[w] | ADR_W'(ofs);
         cpu_read(adr, WIN_DEV[w]);
      end
      end_test("decode");
   endtask

   task automatic test_dma_grant();
      dma_start(1, RK_BASE | 17'o2, 1'b1);
      wait_falls(1);
      check_gnt(2'b00);                  // request not seen by an edge yet
      wait_falls(1);
      check_gnt(2'b10);
      dma_finish(1, DEV_RK);
      wait_falls(2);
      check_gnt(2'b00);
      // both at once, dma 0 wins and dma 1 follows without a cpu slot
      drive_edge();
      dma_start(0, DW_BASE, 1'b1);
      dma_start(1, MY_BASE, 1'b1);
      wait_falls(2);
      check_gnt(2'b01);
      dma_finish(0, DEV_DW);
      wait_falls(2);
      check_gnt(2'b10);
      dma_finish(1, DEV_MY);
      wait_falls(2);
      check_gnt(2'b00);
      // open cpu cycle without stb holds the bus
      drive_edge();
      cpu_req.cyc = 1'b1;
      dma_start(0, RX_BASE, 1'b1);
      repeat (4) begin
         wait_falls(1);
         check_gnt(2'b00);
      end
      drive_edge();
      cpu_req.cyc = 1'b0;
      wait_falls(1);
      check_gnt(2'b00);
      wait_falls(1);
      check_gnt(2'b01);
      dma_finish(0, DEV_RX);
      wait_falls(2);
      check_gnt(2'b00);
      drive_edge();
      end_test("dma grant");
   endtask

   task automatic test_ack_steering();
      dma_start(0, KGD_BASE | 17'o4, 1'b0);
      wait_falls(2);
      check_gnt(2'b01);
      expect_eq("dma_ack_o", 32'(dma_ack), 32'h0);
      dma_finish(0, DEV_KGD);
      wait_falls(1);
      expect_eq("dma_ack_o", 32'(dma_ack), 32'h0);   // single pulse
      expect_eq("cpu_ack_o", 32'(cpu_ack), 32'h0);
      wait_falls(1);
      check_gnt(2'b00);
      drive_edge();
      end_test("ack steering");
   endtask

   task automatic test_sd_ownership();
      sd_req = 4'b1010;
      wait_falls(1);
      expect_eq("sd_ack_o", 32'(sd_ack), 32'h0);
      expect_eq("sd_lines_o", 32'(sd_lines_out), 32'(sd_lines[SD_DEF_PORT]));
      wait_falls(1);
      expect_eq("sd_ack_o", 32'(sd_ack), 32'b0010);  // lowest port first
      expect_eq("sd_lines_o", 32'(sd_lines_out), 32'(sd_lines[1]));
      drive_edge();
      sd_lines[1] = 2'b00;               // owner moves its lines
      wait_falls(1);
      expect_eq("sd_lines_o", 32'(sd_lines_out), 32'(sd_lines[1]));
      drive_edge();
      sd_req[1] = 1'b0;
      wait_falls(1);
      expect_eq("sd_ack_o", 32'(sd_ack), 32'b0010);
      wait_falls(1);
      expect_eq("sd_ack_o", 32'(sd_ack), 32'h0);     // idle gap
      expect_eq("sd_lines_o", 32'(sd_lines_out), 32'(sd_lines[SD_DEF_PORT]));
      wait_falls(1);
      expect_eq("sd_ack_o", 32'(sd_ack), 32'b1000);
      expect_eq("sd_lines_o", 32'(sd_lines_out), 32'(sd_lines[3]));
      drive_edge();
      sd_req = '0;
      wait_falls(2);
      expect_eq("sd_ack_o", 32'(sd_ack), 32'h0);
      drive_edge();
      end_test("sd ownership");
   endtask

`endif

// File: verif/tb_system_bus_fabric.sv
/*
 * testbench for the system bus fabric
 * clock, reset, device response models and the run timeout
 * directed tests live in the included task file
 */
`timescale 1ns/1ps
`default_nettype none

module tb_system_bus_fabric;
   import bus_pkg::*;
   import sd_pkg::*;

   localparam int CLK_PER     = 40;
   localparam int DRV_DLY     = 2;      // input skew after the rising edge
   localparam int RST_CYCLES  = 5;
   localparam int SD_DEF_PORT = 2;      // idle card driver
   localparam int TIMEOUT_CYC = 2000;   // full run needs ~150 clocks

   logic                          wb_clk;
   logic                          rst_i;
   wb_req_t                       cpu_req;
   wb_req_t [NUM_DMA-1:0]         dma_req;
   logic                          cpu_gnt;
   logic                          cpu_ack;
   logic [NUM_DMA-1:0]            dma_gnt;
   logic [NUM_DMA-1:0]            dma_ack;
   logic [DAT_W-1:0]              rd_dat;
   wb_req_t                       bus_view;      // forwarded request
   dev_sel_t                      dev_stb;
   dev_sel_t                      dev_ack = '0;
   logic [NUM_DEV-1:0][DAT_W-1:0] dev_dat;
   logic [NUM_SD-1:0]             sd_req;
   logic [NUM_SD-1:0]             sd_ack;
   sd_lines_t [NUM_SD-1:0]        sd_lines;
   sd_lines_t                     sd_lines_out;

   int          err_cnt;
   int          test_err;       // errors of the running test
   int          test_cnt;
   int          fail_cnt;
   int          cyc_cnt = 0;
   logic [31:0] lfsr_q;

   `include "tb_fabric_tasks.svh"

   initial begin
      wb_clk = 1'b0;
      forever #(CLK_PER/2) wb_clk = ~wb_clk;
   end

   // **************************************************
   // device models
   // **************************************************
   always @(posedge wb_clk) begin
      dev_ack <= rst_i ? '0 : (dev_stb & ~dev_ack);   // one pulse, a clock after stb
   end

   always_comb begin
      for (int i = 0; i < NUM_DEV; i++) begin
         dev_dat[i] = model_data(i, bus_view.adr);
      end
   end

   always @(posedge wb_clk) begin
      cyc_cnt <= cyc_cnt + 1;
      if (cyc_cnt == TIMEOUT_CYC) begin
         $display("timeout, run stopped after %0d clock cycles", cyc_cnt);
         $display("** FAIL **");
         $finish;
      end
   end

   system_bus_fabric #(
      .NUM_DMA_P       (NUM_DMA),
      .NUM_SD_P        (NUM_SD),
      .DEFAULT_SD_PORT (SD_DEF_PORT)
   ) system_bus_fabric_i (
      .wb_clk     (wb_clk),
      .rst_i      (rst_i),
      .cpu_req_i  (cpu_req),
      .dma_req_i  (dma_req),
      .cpu_gnt_o  (cpu_gnt),
      .cpu_ack_o  (cpu_ack),
      .dma_gnt_o  (dma_gnt),
      .dma_ack_o  (dma_ack),
      .rd_dat_o   (rd_dat),
      .bus_o      (bus_view),
      .dev_stb_o  (dev_stb),
      .dev_ack_i  (dev_ack),
      .dev_dat_i  (dev_dat),
      .sd_req_i   (sd_req),
      .sd_lines_i (sd_lines),
      .sd_ack_o   (sd_ack),
      .sd_lines_o (sd_lines_out)
   );

   // **************************************************
   // test sequence
   // **************************************************
   initial begin
      rst_i    = 1'b1;
      cpu_req  = '0;
      dma_req  = '0;
      sd_req   = '0;
      lfsr_q   = 32'h1d480a63;
      err_cnt  = 0;
      test_err = 0;
      test_cnt = 0;
      fail_cnt = 0;
      for (int n = 0; n < NUM_SD; n++) begin
         sd_lines[n] = 2'(n);          // distinct lines per port
      end
      repeat (RST_CYCLES) @(posedge wb_clk);
      #DRV_DLY;
      rst_i = 1'b0;

      test_reset_state();
      test_decode();
      test_dma_grant();
      test_ack_steering();
      test_sd_ownership();

      $display("%0d tests, %0d failed, %0d errors", test_cnt, fail_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: compile.f
+incdir+verif
src/bus_pkg.sv
src/sd_pkg.sv
src/bus_master_arbiter.sv
src/io_page_decoder.sv
src/sd_card_arbiter.sv
src/system_bus_fabric.sv
verif/tb_system_bus_fabric.sv

// File: Makefile
# Verilator flow for the system bus fabric testbench
# override from the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_system_bus_fabric
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

SOURCES := $(wildcard src/*.sv verif/*.sv verif/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -qx '\*\* PASS \*\*' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
